// ==== common/miniSrc_config.svh ====
`ifndef MINISRC_CONFIG_SVH
`define MINISRC_CONFIG_SVH

// bus and register width
`define DATA_WIDTH 32
`define REG_COUNT 16

// ram word address bits for 512 words
`define MEM_ADDR_BITS 9
`define RAM_WAIT_STATES 0

`endif

// ==== common/cpuPkg.sv ====
package cpuPkg;

	// opcode field of the instruction word
	typedef enum logic [4:0] {
		opAdd  = 5'd0,
		opSub  = 5'd1,
		opAnd  = 5'd2,
		opOr   = 5'd3,
		opShr  = 5'd4,
		opShra = 5'd5,
		opShl  = 5'd6,
		opRor  = 5'd7,
		opRol  = 5'd8,
		opAddi = 5'd9,
		opAndi = 5'd10,
		opOri  = 5'd11,
		opMul  = 5'd12,
		opDiv  = 5'd13,
		opNeg  = 5'd14,
		opNot  = 5'd15,
		opLd   = 5'd16,
		opSt   = 5'd17,
		opBr   = 5'd18
	} aluOpT;

	typedef struct packed {
		aluOpT opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [3:0] rc;
		logic [14:0] unused;
	} rFormT;

	// immediate and branch layout with cond in rb[1:0]
	typedef struct packed {
		aluOpT opcode;
		logic [3:0] ra;
		logic [3:0] rb;
		logic [18:0] c;
	} iFormT;

	typedef union packed {
		rFormT rForm;
		iFormT iForm;
	} instrWordT;

	typedef enum logic [1:0] {
		condZero     = 2'd0,
		condNonZero  = 2'd1,
		condPositive = 2'd2,
		condNegative = 2'd3
	} branchCondT;

endpackage

// ==== common/memBusIf.sv ====
`timescale 1ns/100ps
`include "miniSrc_config.svh"

// wishbone classic link between datapath and ram
interface memBusIf;
	logic [`MEM_ADDR_BITS-1:0] adr;
	logic [`DATA_WIDTH-1:0] datW;
	logic [`DATA_WIDTH-1:0] datR;
	logic we;
	logic cyc;
	logic stb;
	logic ack;

	modport master (
		output adr, datW, we, cyc, stb,
		input datR, ack
	);

	modport slave (
		input adr, datW, we, cyc, stb,
		output datR, ack
	);
endinterface

// ==== datapath/regFile.sv ====
`timescale 1ns/100ps
`include "miniSrc_config.svh"

module regFile (
	input logic clock,
	input logic arstN,
	input logic baOut,
	input logic [`REG_COUNT-1:0] loadSel,
	input logic [`REG_COUNT-1:0] readSel,
	input logic [`DATA_WIDTH-1:0] busIn,
	output logic [`DATA_WIDTH-1:0] regOut
);
	logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				if (loadSel[i]) begin
					regs[i] <= busIn;
				end
			end
		end
	end

	// r0 reads as zero for base address mode
	always_comb begin
		regOut = '0;
		for (int i = 0; i < `REG_COUNT; i++) begin
			if (readSel[i] && !(i == 0 && baOut)) begin
				regOut = regOut | regs[i];
			end
		end
	end
endmodule

// ==== datapath/selEncode.sv ====
`timescale 1ns/100ps
`include "miniSrc_config.svh"

module selEncode (
	input cpuPkg::instrWordT ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	output logic [`REG_COUNT-1:0] loadSel,
	output logic [`REG_COUNT-1:0] readSel,
	output logic [`DATA_WIDTH-1:0] cSignExt,
	output cpuPkg::aluOpT aluOp,
	output cpuPkg::branchCondT cond
);
	import cpuPkg::*;

	localparam int IDX_BITS = $clog2(`REG_COUNT);

	logic [IDX_BITS-1:0] regIdx;
	logic [`REG_COUNT-1:0] oneHot;
	logic anyField;

	// pick the register field
	always_comb begin
		regIdx = '0;
		if (gra) regIdx = ir.rForm.ra;
		else if (grb) regIdx = ir.rForm.rb;
		else if (grc) regIdx = ir.rForm.rc;
	end

	assign anyField = gra || grb || grc;
	assign oneHot = `REG_COUNT'(1) << regIdx;

	assign loadSel = (rIn && anyField) ? oneHot : '0;
	assign readSel = ((rOut || baOut) && anyField) ? oneHot : '0;

	assign cSignExt = {{(`DATA_WIDTH - 19){ir.iForm.c[18]}}, ir.iForm.c};
	assign aluOp = ir.rForm.opcode;
	// branch condition in low bits of rb
	assign cond = branchCondT'(ir.iForm.rb[1:0]);
endmodule

// ==== datapath/alu.sv ====
`timescale 1ns/100ps
`include "miniSrc_config.svh"

module alu (
	input logic [`DATA_WIDTH-1:0] a,
	input logic [`DATA_WIDTH-1:0] b,
	input cpuPkg::aluOpT op,
	output logic [`DATA_WIDTH-1:0] resLow,
	output logic [`DATA_WIDTH-1:0] resHigh
);
	import cpuPkg::*;

	localparam int W = `DATA_WIDTH;
	localparam int SH_BITS = $clog2(`DATA_WIDTH);

	logic [SH_BITS-1:0] shAmt;
	logic [2*W-1:0] dbl, rorDbl, rolDbl;
	logic signed [2*W-1:0] product;
	logic [W-1:0] divisor;
	logic signed [W-1:0] quot, rem;

	assign shAmt = b[SH_BITS-1:0];

	// rotates through a doubled word
	assign dbl = {a, a};
	assign rorDbl = dbl >> shAmt;
	assign rolDbl = dbl << shAmt;

	assign product = $signed(a) * $signed(b);

	// keep the divider defined when b is zero
	assign divisor = (b == '0) ? W'(1) : b;
	assign quot = $signed(a) / $signed(divisor);
	assign rem = $signed(a) % $signed(divisor);

	always_comb begin
		resLow = '0;
		resHigh = '0;
		case (op)
			opAdd, opAddi, opLd, opSt, opBr: resLow = a + b;
			opSub: resLow = a - b;
			opAnd, opAndi: resLow = a & b;
			opOr, opOri: resLow = a | b;
			opShr: resLow = a >> shAmt;
			opShra: resLow = $signed(a) >>> shAmt;
			opShl: resLow = a << shAmt;
			opRor: resLow = rorDbl[W-1:0];
			opRol: resLow = rolDbl[2*W-1:W];
			opMul: begin
				resLow = product[W-1:0];
				resHigh = product[2*W-1:W];
			end
			opDiv: begin
				if (b == '0) begin
					resLow = '1;
					resHigh = a;
				end else begin
					resLow = quot;
					resHigh = rem;
				end
			end
			// neg and not act on the bus operand
			opNeg: resLow = -b;
			opNot: resLow = ~b;
			default: resLow = '0;
		endcase
	end
endmodule

// ==== hw/wbRam.sv ====
`timescale 1ns/100ps
`include "miniSrc_config.svh"

module wbRam (
	input logic clock,
	input logic arstN,
	memBusIf.slave bus
);
	localparam int CNT_BITS = $clog2(`RAM_WAIT_STATES + 2);

	logic [`DATA_WIDTH-1:0] mem [2**`MEM_ADDR_BITS];
	logic [CNT_BITS-1:0] waitCnt;
	logic ackNext;

	assign ackNext = bus.cyc && bus.stb && !bus.ack
		&& (waitCnt == CNT_BITS'(`RAM_WAIT_STATES));

	// wait counter and single-cycle ack
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			bus.ack <= 1'b0;
			waitCnt <= '0;
		end else begin
			bus.ack <= ackNext;
			if (bus.ack || !(bus.cyc && bus.stb)) waitCnt <= '0;
			else if (!ackNext) waitCnt <= waitCnt + CNT_BITS'(1);
		end
	end

	always_ff @(posedge clock) begin
		if (ackNext) bus.datR <= mem[bus.adr];
		if (bus.ack && bus.we) mem[bus.adr] <= bus.datW;
	end
endmodule

// ==== datapath/dataPath.sv ====
`timescale 1ns/100ps
`include "miniSrc_config.svh"

module dataPath (
	input logic clock,
	input logic arstN,
	input logic read, write, strobe, baOut,
	input logic gra, grb, grc, rIn, rOut, cOut,
	input logic hiIn, loIn, hiOut, loOut,
	input logic zHighIn, zLowIn, zHighOut, zLowOut,
	input logic pcIn, pcOut, incPc,
	input logic mdrIn, mdrOut, marIn, irIn, yIn,
	input logic outPortIn, inPortOut, conIn,
	input logic [`DATA_WIDTH-1:0] inData,
	output logic [`DATA_WIDTH-1:0] busOut,
	output logic [`DATA_WIDTH-1:0] outData,
	output logic branchTaken,
	output logic memDone
);
	import cpuPkg::*;

	logic [`DATA_WIDTH-1:0] hi, lo, y, zHigh, zLow, pc, mdr, inPort, outPort;
	logic [`MEM_ADDR_BITS-1:0] mar;
	instrWordT ir;
	logic [`REG_COUNT-1:0] loadSel, readSel;
	logic [`DATA_WIDTH-1:0] regOut, cSignExt, aluLow, aluHigh, zLowNext;
	aluOpT aluOp;
	branchCondT cond;
	logic condMet;
	logic memCyc, memWe, waitRelease, readAck;

	memBusIf memBus();

	regFile uRegFile (.clock, .arstN, .baOut, .loadSel, .readSel, .busIn(busOut), .regOut);

	selEncode uSelEncode (.ir, .gra, .grb, .grc, .rIn, .rOut, .baOut,
		.loadSel, .readSel, .cSignExt, .aluOp, .cond);

	alu uAlu (.a(y), .b(busOut), .op(aluOp), .resLow(aluLow), .resHigh(aluHigh));

	wbRam uRam (.clock, .arstN, .bus(memBus.slave));

	// one-hot sources ORed together
	// an idle bus reads as zero
	assign busOut = regOut
		| ({`DATA_WIDTH{hiOut}} & hi)
		| ({`DATA_WIDTH{loOut}} & lo)
		| ({`DATA_WIDTH{zHighOut}} & zHigh)
		| ({`DATA_WIDTH{zLowOut}} & zLow)
		| ({`DATA_WIDTH{pcOut}} & pc)
		| ({`DATA_WIDTH{mdrOut}} & mdr)
		| ({`DATA_WIDTH{inPortOut}} & inPort)
		| ({`DATA_WIDTH{cOut}} & cSignExt);

	assign zLowNext = incPc ? pc + `DATA_WIDTH'(1) : aluLow;

	// positive means strictly above zero
	always_comb begin
		case (cond)
			condZero:     condMet = (busOut == '0);
			condNonZero:  condMet = (busOut != '0);
			condPositive: condMet = !busOut[`DATA_WIDTH-1] && (busOut != '0);
			default:      condMet = busOut[`DATA_WIDTH-1];
		endcase
	end

	assign readAck = memCyc && memBus.ack && !memWe;

	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			hi <= '0;
			lo <= '0;
			y <= '0;
			zHigh <= '0;
			zLow <= '0;
			pc <= '0;
			ir <= '0;
			mar <= '0;
			mdr <= '0;
			inPort <= '0;
			outPort <= '0;
			branchTaken <= 1'b0;
		end else begin
			if (hiIn) hi <= busOut;
			if (loIn) lo <= busOut;
			if (yIn) y <= busOut;
			if (zHighIn) zHigh <= aluHigh;
			if (zLowIn) zLow <= zLowNext;
			if (pcIn) pc <= busOut;
			if (irIn) ir <= busOut;
			if (marIn) mar <= busOut[`MEM_ADDR_BITS-1:0];
			if (mdrIn) mdr <= busOut;
			else if (readAck) mdr <= memBus.datR;
			if (strobe) inPort <= inData;
			if (outPortIn) outPort <= busOut;
			if (conIn) branchTaken <= condMet;
		end
	end

	// wishbone master issues one cycle per read or write request
	always_ff @(posedge clock or negedge arstN) begin
		if (!arstN) begin
			memCyc <= 1'b0;
			memWe <= 1'b0;
			waitRelease <= 1'b0;
		end else if (memCyc) begin
			if (memBus.ack) begin
				memCyc <= 1'b0;
				waitRelease <= 1'b1;
			end
		end else if (waitRelease) begin
			// request must drop before the next cycle
			if (!read && !write) waitRelease <= 1'b0;
		end else if (read || write) begin
			memCyc <= 1'b1;
			memWe <= write;
		end
	end

	assign memBus.adr = mar;
	assign memBus.datW = mdr;
	assign memBus.we = memWe;
	assign memBus.cyc = memCyc;
	assign memBus.stb = memCyc;
	assign memDone = memBus.ack;
	assign outData = outPort;
endmodule

// ==== sim/dataPath_props.sv ====
`timescale 1ns/100ps
`include "miniSrc_config.svh"

module dataPathProps (
	input logic clock,
	input logic arstN,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic [`MEM_ADDR_BITS-1:0] adr,
	input logic [8:0] srcEn
);
	// master closes the cycle right after the ack
	cycEndsAfterAck: assert property (@(posedge clock) disable iff (!arstN) ack |=> !cyc)
		else $error("wishbone cyc still high after ack");

	ackNeedsStb: assert property (@(posedge clock) disable iff (!arstN) ack |-> stb)
		else $error("wishbone ack while stb is low");

	// ack is a single-cycle pulse
	ackOneCycle: assert property (@(posedge clock) disable iff (!arstN) ack |=> !ack)
		else $error("wishbone ack held longer than one cycle");

	adrStable: assert property (@(posedge clock) disable iff (!arstN)
		(stb && !ack) |=> $stable(adr))
		else $error("wishbone adr changed while waiting for ack");

	oneBusSource: assert property (@(posedge clock) disable iff (!arstN) $onehot0(srcEn))
		else $error("more than one bus source enabled");
endmodule

bind dataPath dataPathProps uProps (
	.clock(clock),
	.arstN(arstN),
	.cyc(memBus.cyc),
	.stb(memBus.stb),
	.ack(memBus.ack),
	.adr(memBus.adr),
	.srcEn({(|readSel), hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, cOut})
);

// ==== sim/dataPathTb.sv ====
`timescale 1ns/100ps
`include "miniSrc_config.svh"

module dataPathTb;
	localparam int MAX_STEPS = 256;
	localparam int FIELDS = 5;

	logic clock;
	logic arstN;
	logic read, write, strobe, baOut, gra, grb, grc, rIn, rOut, cOut;
	logic hiIn, loIn, hiOut, loOut, zHighIn, zLowIn, zHighOut, zLowOut;
	logic pcIn, pcOut, incPc, mdrIn, mdrOut, marIn, irIn, yIn;
	logic outPortIn, inPortOut, conIn;
	logic [`DATA_WIDTH-1:0] inData;
	logic [`DATA_WIDTH-1:0] busOut;
	logic [`DATA_WIDTH-1:0] outData;
	logic branchTaken;
	logic memDone;

	// control word bits 28:0, bit 30 waits for memDone, bit 31 ends the list
	logic [28:0] ctrlBits;
	logic [31:0] tests [MAX_STEPS*FIELDS];
	int stepCount = 0;

	assign {conIn, inPortOut, outPortIn, yIn, irIn, marIn, mdrOut, mdrIn, incPc,
		pcOut, pcIn, zLowOut, zHighOut, zLowIn, zHighIn, loOut, hiOut, loIn, hiIn,
		cOut, rOut, rIn, grc, grb, gra, baOut, strobe, write, read} = ctrlBits;

	dataPath DUT (.*);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	task automatic failRun(input string reason);
		$display("%s", reason);
		$display("Regression failed");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
		input string what, input int step);
		if (actual !== expected) begin
			failRun($sformatf("MISMATCH at %0.1f ns: step %0d %s is %h, expected %h",
				$realtime, step, what, actual, expected));
		end
	endtask

	// index of the end marker line
	function automatic int countSteps();
		for (int i = 0; i < MAX_STEPS; i++) begin
			if (tests[i*FIELDS][31] === 1'b1) return i;
		end
		return -1;
	endfunction

	initial begin
		wait (stepCount > 0);
		repeat (stepCount * (`RAM_WAIT_STATES + 4) + 20) @(posedge clock);
		failRun("simulation hung, watchdog timer expired");
	end

	initial begin
		logic [31:0] ctrl;
		logic [31:0] mask;
		int base;
		int total;
		ctrlBits = '0;
		inData = '0;
		arstN = 1'b0;
		$readmemh("sim/microstep_tests.mem", tests);
		total = countSteps();
		if (total < 0) failRun("test file has no end marker");
		stepCount = total;
		repeat (3) @(posedge clock);
		arstN <= 1'b1;
		for (int step = 0; step < total; step++) begin
			base = step * FIELDS;
			ctrl = tests[base];
			mask = tests[base+4];
			@(posedge clock);
			ctrlBits <= ctrl[28:0];
			inData <= tests[base+1];
			@(negedge clock);
			// memory steps hold until the ack
			if (ctrl[30]) begin
				while (!memDone) @(negedge clock);
			end
			if (mask[0]) checkValue(busOut, tests[base+2], "busOut", step);
			if (mask[1]) checkValue(outData, tests[base+3], "outData", step);
			if (mask[2]) checkValue({31'b0, branchTaken}, {31'b0, mask[4]}, "branchTaken", step);
		end
		$display("Regression passed");
		$finish;
	end
endmodule

// ==== miniSrc.f ====
+incdir+common
common/cpuPkg.sv
common/memBusIf.sv
datapath/regFile.sv
datapath/selEncode.sv
datapath/alu.sv
hw/wbRam.sv
datapath/dataPath.sv
sim/dataPath_props.sv
sim/dataPathTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# builds the datapath regression with Verilator and runs it from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dataPathTb \
	-f miniSrc.f -o dataPathSim &&
./obj_dir/dataPathSim || { echo "build or simulation failed" >&2; exit 1; }

// ==== sim/microstep_tests.mem ====
// columns: control word, inData, expected busOut, expected outData, check mask
// mask bit0 bus, bit1 outData, bit2 branchTaken, bit4 expected branchTaken
// load IR, R1, HI, LO, R0, R2 and Y through the input port
00000004 00900000 00000000 00000000 00
09000004 12345678 00900000 00000000 01
08000C94 00000ABC 12345678 00000000 01
080000C4 00000007 00000ABC 00000000 01
080000A4 F0000013 00000007 00000000 01
0A000004 08900000 F0000013 00000000 01
00000110 00000000 12345678 00000000 01
00002000 00000000 12345678 00000000 01
00000140 00000000 00000ABC 00000000 01
00000048 00000000 00000000 00000000 01
// add, sub, and, shra, rol, neg with Y = F0000013
00008120 00000000 00000007 00000000 01
00020000 00000000 F000001A 00000000 01
09000004 10900000 08900000 00000000 01
00008120 00000000 00000007 00000000 01
00020000 00000000 F000000C 00000000 01
09000004 28900000 10900000 00000000 01
00008120 00000000 00000007 00000000 01
00020000 00000000 00000003 00000000 01
09000004 40900000 28900000 00000000 01
00008110 00000000 12345678 00000000 01
00020000 00000000 FFFFFFF0 00000000 01
09000004 70900000 40900000 00000000 01
00008120 00000000 00000007 00000000 01
00020000 00000000 000009F8 00000000 01
09000004 60900000 70900000 00000000 01
00008120 00000000 00000007 00000000 01
00020000 00000000 FFFFFFF9 00000000 01
// mul into HI and LO, then div
09000004 68900000 60900000 00000000 01
0000C120 00000000 00000007 00000000 01
00010400 00000000 FFFFFFFF 00000000 01
00020800 00000000 90000085 00000000 01
00002000 00000000 90000085 00000000 01
09000004 4897FFF0 68900000 00000000 01
0000C120 00000000 00000007 00000000 01
00010000 00000000 FFFFFFFC 00000000 01
00020000 00000000 FDB6DB71 00000000 01
// incPc, then addi with constant -16
00040140 00000000 00000ABC 00000000 01
09108004 000001A5 4897FFF0 00000000 01
00020000 00000000 00000ABD 00000000 01
00000200 00000000 FFFFFFF0 00000000 01
02000110 00000000 12345678 00000000 01
00008200 00000000 FFFFFFF0 00000000 01
00020000 00000000 12345668 00000000 01
// two stores, then two loads
08800004 CAFEF00D 000001A5 00000000 01
08200004 0000005A CAFEF00D 00000000 01
40000002 00000000 00000000 00000000 00
08800004 0BADBEEF 0000005A 00000000 01
08200004 000001A5 0BADBEEF 00000000 01
40000002 00000000 00000000 00000000 00
08800004 0000005A 000001A5 00000000 01
40000001 00000000 00000000 00000000 00
00400000 00000000 CAFEF00D 00000000 01
08800004 90000000 0000005A 00000000 01
40000001 00000000 00000000 00000000 00
00400000 00000000 0BADBEEF 00000000 01
// branch conditions zero, nonZero, positive, negative
09000004 90080000 90000000 00000000 01
10000048 00000000 00000000 00000000 01
09000004 90100000 90080000 00000000 15
10000048 00000000 00000000 00000000 01
09000004 90180000 90100000 00000000 05
10400000 00000000 0BADBEEF 00000000 05
09000004 87654321 90180000 00000000 15
10400000 00000000 0BADBEEF 00000000 15
10001000 00000000 FFFFFFFF 00000000 05
// output port loads only on outPortIn and then holds
0C000000 00000000 87654321 00000000 17
00001000 00000000 FFFFFFFF 87654321 03
00000000 00000000 00000000 87654321 03
80000000 00000000 00000000 00000000 00
